// ==== hdl/dm_cache_cfg_pkg.sv ====
`default_nettype none

package dm_cache_cfg_pkg;

    // Defaults picked up by the top level.
    localparam int DEF_ADDR_WIDTH = 16;  // Byte address.
    localparam int DEF_DATA_WIDTH = 32;
    localparam int DEF_INDEX_BITS = 6;   // 64 lines.

    // Address split is tag | index | offset.
    // All accesses are full words, so the offset bits are always zero.
    localparam int OFFSET_BITS = 2;

    // Width of every performance counter.
    localparam int COUNT_WIDTH = 32;

endpackage

`default_nettype wire

// ==== hdl/dm_cache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module dm_cache_ctrl
    import dm_cache_cfg_pkg::*;
    import dm_cache_types_pkg::*;
#(
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int DATA_WIDTH = DEF_DATA_WIDTH,
    parameter int INDEX_BITS = DEF_INDEX_BITS,
    localparam int TAG_BITS = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS
)
(
    input  wire                   clk,
    input  wire                   rst_n,

    input  wire                   proc_req_i,
    input  wire  [ADDR_WIDTH-1:0] proc_addr_i,
    input  wire                   proc_we_i,
    input  wire  [DATA_WIDTH-1:0] proc_wdata_i,
    output logic                  proc_gnt_o,
    output logic                  proc_rvalid_o,
    output logic [DATA_WIDTH-1:0] proc_rdata_o,

    input  wire                   mem_gnt_i,
    input  wire                   mem_rvalid_i,
    input  wire  [DATA_WIDTH-1:0] mem_rdata_i,
    output logic                  mem_req_o,
    output logic [ADDR_WIDTH-1:0] mem_addr_o,
    output logic                  mem_we_o,
    output logic [DATA_WIDTH-1:0] mem_wdata_o,

    output logic                  lookup_en_o,
    output logic [INDEX_BITS-1:0] lookup_index_o,
    output logic [TAG_BITS-1:0]   lookup_tag_o,
    output logic                  tag_wr_o,
    output logic                  wr_dirty_o,
    output logic                  data_wr_o,
    output logic [DATA_WIDTH-1:0] wr_data_o,
    input  wire                   line_valid_i,
    input  wire                   line_dirty_i,
    input  wire  [TAG_BITS-1:0]   line_tag_i,
    input  wire                   tag_hit_i,
    input  wire  [DATA_WIDTH-1:0] line_data_i,

    output logic                  ev_hit_o,
    output logic                  ev_miss_o,
    output logic                  ev_mem_txn_o,
    output logic                  ev_writeback_o,
    output access_kind_e          ev_kind_o
);

    ctrl_state_e           state_q;
    access_kind_e          kind_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [DATA_WIDTH-1:0] wdata_q;
    logic [ADDR_WIDTH-1:0] req_addr;
    logic                  wb_needed;
    logic                  resolve_now;
    logic                  store_write;
    logic                  fill_done;

    // Live address while idle, latched one afterwards.
    assign req_addr = (state_q == IDLE) ? proc_addr_i : addr_q;

    assign lookup_en_o    = (state_q == IDLE) && proc_req_i;
    assign lookup_index_o = req_addr[OFFSET_BITS +: INDEX_BITS];
    assign lookup_tag_o   = req_addr[ADDR_WIDTH-1 -: TAG_BITS];

    assign wb_needed   = line_valid_i && line_dirty_i && !tag_hit_i;
    // Hit, or a store miss over a clean line. No memory traffic needed.
    assign resolve_now = tag_hit_i || ((kind_q == ACC_STORE) && !wb_needed);

    assign store_write = (kind_q == ACC_STORE) &&
                         (((state_q == COMPARE) && resolve_now) ||
                          ((state_q == WB_WAIT) && mem_rvalid_i));
    assign fill_done   = (state_q == FILL_WAIT) && mem_rvalid_i;

    assign tag_wr_o   = store_write || fill_done;
    assign data_wr_o  = store_write || fill_done;
    assign wr_dirty_o = (kind_q == ACC_STORE);  // Fills land clean.
    assign wr_data_o  = fill_done ? mem_rdata_i : wdata_q;

    // Array outputs hold during a miss, so the victim is read from them directly.
    assign mem_req_o   = (state_q == WB_REQ) || (state_q == FILL_REQ);
    assign mem_we_o    = (state_q == WB_REQ);
    assign mem_addr_o  = (state_q == WB_REQ) ?
                         {line_tag_i, addr_q[OFFSET_BITS +: INDEX_BITS], {OFFSET_BITS{1'b0}}} :
                         addr_q;
    assign mem_wdata_o = line_data_i;

    assign ev_hit_o       = (state_q == COMPARE) && tag_hit_i;
    assign ev_miss_o      = (state_q == COMPARE) && !tag_hit_i;
    assign ev_mem_txn_o   = ((state_q == WB_WAIT) || (state_q == FILL_WAIT)) && mem_rvalid_i;
    assign ev_writeback_o = (state_q == WB_WAIT) && mem_rvalid_i;
    assign ev_kind_o      = kind_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q <= IDLE;
            proc_gnt_o <= 1'b0;
            proc_rvalid_o <= 1'b0;
        end
        else
        begin
            proc_gnt_o <= 1'b0;
            proc_rvalid_o <= 1'b0;
            unique case (state_q)
                IDLE:
                begin
                    if (proc_req_i)
                        state_q <= COMPARE;
                end
                COMPARE:
                begin
                    if (resolve_now)
                    begin
                        proc_gnt_o <= 1'b1;
                        state_q <= RESPOND;
                    end
                    else if (wb_needed)
                        state_q <= WB_REQ;
                    else
                        state_q <= FILL_REQ;
                end
                WB_REQ:
                begin
                    if (mem_gnt_i)
                        state_q <= WB_WAIT;
                end
                WB_WAIT:
                begin
                    if (mem_rvalid_i && (kind_q == ACC_STORE))
                    begin
                        proc_gnt_o <= 1'b1;
                        state_q <= RESPOND;
                    end
                    else if (mem_rvalid_i)
                        state_q <= FILL_REQ;
                end
                FILL_REQ:
                begin
                    if (mem_gnt_i)
                        state_q <= FILL_WAIT;
                end
                FILL_WAIT:
                begin
                    if (mem_rvalid_i)
                    begin
                        proc_gnt_o <= 1'b1;
                        state_q <= RESPOND;
                    end
                end
                RESPOND:
                begin
                    proc_rvalid_o <= 1'b1;
                    state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (lookup_en_o)
        begin
            addr_q <= proc_addr_i;
            wdata_q <= proc_wdata_i;
            kind_q <= proc_we_i ? ACC_STORE : ACC_LOAD;
        end
        if (ev_hit_o && (kind_q == ACC_LOAD))
            proc_rdata_o <= line_data_i;
        else if (fill_done)
            proc_rdata_o <= mem_rdata_i;  // Held until rvalid.
    end

endmodule

`default_nettype wire

// ==== hdl/dm_cache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module dm_cache_top
    import dm_cache_cfg_pkg::*;
    import dm_cache_types_pkg::*;
#(
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int DATA_WIDTH = DEF_DATA_WIDTH,
    parameter int INDEX_BITS = DEF_INDEX_BITS
)
(
    input  wire                    clk,
    input  wire                    rst_n,

    input  wire                    proc_req_i,
    input  wire  [ADDR_WIDTH-1:0]  proc_addr_i,
    input  wire                    proc_we_i,
    input  wire  [DATA_WIDTH-1:0]  proc_wdata_i,
    output logic                   proc_gnt_o,
    output logic                   proc_rvalid_o,
    output logic [DATA_WIDTH-1:0]  proc_rdata_o,

    input  wire                    mem_gnt_i,
    input  wire                    mem_rvalid_i,
    input  wire  [DATA_WIDTH-1:0]  mem_rdata_i,
    output logic                   mem_req_o,
    output logic [ADDR_WIDTH-1:0]  mem_addr_o,
    output logic                   mem_we_o,
    output logic [DATA_WIDTH-1:0]  mem_wdata_o,

    output logic [COUNT_WIDTH-1:0] hit_count_o,
    output logic [COUNT_WIDTH-1:0] miss_count_o,
    output logic [COUNT_WIDTH-1:0] mem_txn_count_o,
    output logic [COUNT_WIDTH-1:0] wb_load_count_o,
    output logic [COUNT_WIDTH-1:0] wb_store_count_o
);

    localparam int TAG_BITS = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;

    logic                  lookup_en;
    logic [INDEX_BITS-1:0] lookup_index;
    logic [TAG_BITS-1:0]   lookup_tag;  // Also the tag written on install.
    logic                  tag_wr;
    logic                  wr_dirty;
    logic                  data_wr;
    logic [DATA_WIDTH-1:0] wr_data;
    logic                  line_valid;
    logic                  line_dirty;
    logic [TAG_BITS-1:0]   line_tag;
    logic                  tag_hit;
    logic [DATA_WIDTH-1:0] line_data;
    logic                  ev_hit;
    logic                  ev_miss;
    logic                  ev_mem_txn;
    logic                  ev_writeback;
    access_kind_e          ev_kind;

    dm_tag_array #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .INDEX_BITS (INDEX_BITS)
    ) i_tag_array (
        .clk            (clk),
        .rst_n          (rst_n),
        .lookup_en_i    (lookup_en),
        .lookup_index_i (lookup_index),
        .lookup_tag_i   (lookup_tag),
        .tag_wr_i       (tag_wr),
        .wr_tag_i       (lookup_tag),
        .wr_dirty_i     (wr_dirty),
        .line_valid_o   (line_valid),
        .line_dirty_o   (line_dirty),
        .line_tag_o     (line_tag),
        .tag_hit_o      (tag_hit)
    );

    dm_data_array #(
        .DATA_WIDTH (DATA_WIDTH),
        .INDEX_BITS (INDEX_BITS)
    ) i_data_array (
        .clk            (clk),
        .lookup_en_i    (lookup_en),
        .lookup_index_i (lookup_index),
        .data_wr_i      (data_wr),
        .wr_data_i      (wr_data),
        .line_data_o    (line_data)
    );

    dm_cache_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .INDEX_BITS (INDEX_BITS)
    ) i_cache_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .proc_req_i     (proc_req_i),
        .proc_addr_i    (proc_addr_i),
        .proc_we_i      (proc_we_i),
        .proc_wdata_i   (proc_wdata_i),
        .proc_gnt_o     (proc_gnt_o),
        .proc_rvalid_o  (proc_rvalid_o),
        .proc_rdata_o   (proc_rdata_o),
        .mem_gnt_i      (mem_gnt_i),
        .mem_rvalid_i   (mem_rvalid_i),
        .mem_rdata_i    (mem_rdata_i),
        .mem_req_o      (mem_req_o),
        .mem_addr_o     (mem_addr_o),
        .mem_we_o       (mem_we_o),
        .mem_wdata_o    (mem_wdata_o),
        .lookup_en_o    (lookup_en),
        .lookup_index_o (lookup_index),
        .lookup_tag_o   (lookup_tag),
        .tag_wr_o       (tag_wr),
        .wr_dirty_o     (wr_dirty),
        .data_wr_o      (data_wr),
        .wr_data_o      (wr_data),
        .line_valid_i   (line_valid),
        .line_dirty_i   (line_dirty),
        .line_tag_i     (line_tag),
        .tag_hit_i      (tag_hit),
        .line_data_i    (line_data),
        .ev_hit_o       (ev_hit),
        .ev_miss_o      (ev_miss),
        .ev_mem_txn_o   (ev_mem_txn),
        .ev_writeback_o (ev_writeback),
        .ev_kind_o      (ev_kind)
    );

    dm_perf_counters i_perf_counters (
        .clk              (clk),
        .rst_n            (rst_n),
        .ev_hit_i         (ev_hit),
        .ev_miss_i        (ev_miss),
        .ev_mem_txn_i     (ev_mem_txn),
        .ev_writeback_i   (ev_writeback),
        .ev_kind_i        (ev_kind),
        .hit_count_o      (hit_count_o),
        .miss_count_o     (miss_count_o),
        .mem_txn_count_o  (mem_txn_count_o),
        .wb_load_count_o  (wb_load_count_o),
        .wb_store_count_o (wb_store_count_o)
    );

endmodule

`default_nettype wire

// ==== hdl/dm_cache_types_pkg.sv ====
`default_nettype none

package dm_cache_types_pkg;

    // Controller FSM states.
    typedef enum logic [2:0] {
        IDLE,
        COMPARE,    // Lookup results valid.
        WB_REQ,
        WB_WAIT,
        FILL_REQ,
        FILL_WAIT,
        RESPOND
    } ctrl_state_e;

    // Kind of processor access.
    typedef enum logic {
        ACC_LOAD  = 1'b0,
        ACC_STORE = 1'b1
    } access_kind_e;

endpackage

`default_nettype wire

// ==== hdl/dm_data_array.sv ====
`timescale 1ns/10ps
`default_nettype none

module dm_data_array
    import dm_cache_cfg_pkg::*;
#(
    parameter int DATA_WIDTH = DEF_DATA_WIDTH,
    parameter int INDEX_BITS = DEF_INDEX_BITS
)
(
    input  wire                   clk,
    input  wire                   lookup_en_i,
    input  wire  [INDEX_BITS-1:0] lookup_index_i,
    input  wire                   data_wr_i,
    input  wire  [DATA_WIDTH-1:0] wr_data_i,
    output logic [DATA_WIDTH-1:0] line_data_o
);

    localparam int NUM_LINES = 2 ** INDEX_BITS;

    logic [DATA_WIDTH-1:0] data_mem [NUM_LINES];
    logic [INDEX_BITS-1:0] index_q;

    // Read port is registered, result one cycle after lookup.
    always_ff @(posedge clk)
    begin
        if (lookup_en_i)
        begin
            index_q <= lookup_index_i;
            line_data_o <= data_mem[lookup_index_i];
        end
    end

    // Writes go to the line last looked up.
    always_ff @(posedge clk)
    begin
        if (data_wr_i)
            data_mem[index_q] <= wr_data_i;
    end

endmodule

`default_nettype wire

// ==== hdl/dm_perf_counters.sv ====
`timescale 1ns/10ps
`default_nettype none

module dm_perf_counters
    import dm_cache_cfg_pkg::*;
    import dm_cache_types_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    ev_hit_i,
    input  wire                    ev_miss_i,
    input  wire                    ev_mem_txn_i,
    input  wire                    ev_writeback_i,
    input  wire access_kind_e      ev_kind_i,
    output logic [COUNT_WIDTH-1:0] hit_count_o,
    output logic [COUNT_WIDTH-1:0] miss_count_o,
    output logic [COUNT_WIDTH-1:0] mem_txn_count_o,
    output logic [COUNT_WIDTH-1:0] wb_load_count_o,
    output logic [COUNT_WIDTH-1:0] wb_store_count_o
);

    localparam int NUM_COUNTERS = 5;

    logic [NUM_COUNTERS-1:0] inc;
    logic [COUNT_WIDTH-1:0]  count_q [NUM_COUNTERS];

    assign inc[0] = ev_hit_i;
    assign inc[1] = ev_miss_i;
    assign inc[2] = ev_mem_txn_i;
    assign inc[3] = ev_writeback_i && (ev_kind_i == ACC_LOAD);  // Split by the missing access.
    assign inc[4] = ev_writeback_i && (ev_kind_i == ACC_STORE);

    // Saturate at all ones.
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < NUM_COUNTERS; i++)
        begin
            if (!rst_n)
                count_q[i] <= '0;
            else if (inc[i] && (count_q[i] != '1))
                count_q[i] <= count_q[i] + 1'b1;
        end
    end

    assign hit_count_o      = count_q[0];
    assign miss_count_o     = count_q[1];
    assign mem_txn_count_o  = count_q[2];
    assign wb_load_count_o  = count_q[3];
    assign wb_store_count_o = count_q[4];

endmodule

`default_nettype wire

// ==== hdl/dm_tag_array.sv ====
`timescale 1ns/10ps
`default_nettype none

module dm_tag_array
    import dm_cache_cfg_pkg::*;
#(
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int INDEX_BITS = DEF_INDEX_BITS,
    localparam int TAG_BITS = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS
)
(
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  lookup_en_i,
    input  wire [INDEX_BITS-1:0] lookup_index_i,
    input  wire [TAG_BITS-1:0]   lookup_tag_i,
    input  wire                  tag_wr_i,
    input  wire [TAG_BITS-1:0]   wr_tag_i,
    input  wire                  wr_dirty_i,
    output logic                 line_valid_o,
    output logic                 line_dirty_o,
    output logic [TAG_BITS-1:0]  line_tag_o,
    output logic                 tag_hit_o
);

    localparam int NUM_LINES = 2 ** INDEX_BITS;

    logic [TAG_BITS-1:0]   tag_mem [NUM_LINES];
    logic [NUM_LINES-1:0]  valid_q;
    logic [NUM_LINES-1:0]  dirty_q;
    logic [INDEX_BITS-1:0] index_q;  // Index of last lookup, also the write index.
    logic [TAG_BITS-1:0]   cmp_tag_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_q <= '0;
            dirty_q <= '0;
            line_valid_o <= 1'b0;
            line_dirty_o <= 1'b0;
        end
        else
        begin
            if (lookup_en_i)
            begin
                line_valid_o <= valid_q[lookup_index_i];
                line_dirty_o <= dirty_q[lookup_index_i];
            end
            if (tag_wr_i)
            begin
                valid_q[index_q] <= 1'b1;
                dirty_q[index_q] <= wr_dirty_i;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (lookup_en_i)
        begin
            index_q <= lookup_index_i;
            cmp_tag_q <= lookup_tag_i;
            line_tag_o <= tag_mem[lookup_index_i];
        end
        if (tag_wr_i)
            tag_mem[index_q] <= wr_tag_i;
    end

    assign tag_hit_o = line_valid_o && (line_tag_o == cmp_tag_q);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module dm_cache_tb -f verilog.f

out=$(./obj_dir/Vdm_cache_tb)
printf '%s\n' "$out"

# Exit status follows the search for the pass line.
printf '%s\n' "$out" | grep -qx "all tests passed"

// ==== tests/dm_cache_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module dm_cache_tb
    import dm_cache_cfg_pkg::*;
();

    localparam int ADDR_WIDTH   = DEF_ADDR_WIDTH;
    localparam int DATA_WIDTH   = DEF_DATA_WIDTH;
    localparam int INDEX_BITS   = 3;  // Eight lines.
    localparam int TAG_BITS     = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;
    localparam int NUM_LINES    = 2 ** INDEX_BITS;
    localparam int TXN_W        = 1 + ADDR_WIDTH + DATA_WIDTH;  // {we, addr, wdata}.
    localparam int NUM_RANDOM   = 400;
    localparam int NUM_ACCESSES = 4 + 2 + 6 + NUM_RANDOM;
    localparam int MAX_CYCLES   = 60 * NUM_ACCESSES;

    wire                    clk;
    wire                    rst_n;
    logic                   proc_req;
    logic [ADDR_WIDTH-1:0]  proc_addr;
    logic                   proc_we;
    logic [DATA_WIDTH-1:0]  proc_wdata;
    wire                    proc_gnt;
    wire                    proc_rvalid;
    wire  [DATA_WIDTH-1:0]  proc_rdata;
    logic                   mem_gnt;
    logic                   mem_rvalid;
    logic [DATA_WIDTH-1:0]  mem_rdata;
    wire                    mem_req;
    wire  [ADDR_WIDTH-1:0]  mem_addr;
    wire                    mem_we;
    wire  [DATA_WIDTH-1:0]  mem_wdata;
    wire  [COUNT_WIDTH-1:0] hit_count;
    wire  [COUNT_WIDTH-1:0] miss_count;
    wire  [COUNT_WIDTH-1:0] mem_txn_count;
    wire  [COUNT_WIDTH-1:0] wb_load_count;
    wire  [COUNT_WIDTH-1:0] wb_store_count;

    // Reference model state.
    logic                  m_valid [NUM_LINES];
    logic                  m_dirty [NUM_LINES];
    logic [TAG_BITS-1:0]   m_tag [NUM_LINES];
    logic [DATA_WIDTH-1:0] m_data [NUM_LINES];
    logic [DATA_WIDTH-1:0] model_mem [logic [ADDR_WIDTH-1:0]];
    logic [DATA_WIDTH-1:0] mem_words [logic [ADDR_WIDTH-1:0]];  // Responder copy.
    logic [TXN_W-1:0]      exp_txn_q [$];
    logic [TXN_W-1:0]      seen_txn_q [$];
    int exp_hits;
    int exp_misses;
    int exp_txns;
    int exp_wb_load;
    int exp_wb_store;
    int error_count;
    int start_errors;
    int pass_count;
    int fail_count;
    int cycle_count = 0;

    tb_clock_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (8)
    ) i_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    dm_cache_top #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .INDEX_BITS (INDEX_BITS)
    ) i_dm_cache_top (
        .clk              (clk),
        .rst_n            (rst_n),
        .proc_req_i       (proc_req),
        .proc_addr_i      (proc_addr),
        .proc_we_i        (proc_we),
        .proc_wdata_i     (proc_wdata),
        .proc_gnt_o       (proc_gnt),
        .proc_rvalid_o    (proc_rvalid),
        .proc_rdata_o     (proc_rdata),
        .mem_gnt_i        (mem_gnt),
        .mem_rvalid_i     (mem_rvalid),
        .mem_rdata_i      (mem_rdata),
        .mem_req_o        (mem_req),
        .mem_addr_o       (mem_addr),
        .mem_we_o         (mem_we),
        .mem_wdata_o      (mem_wdata),
        .hit_count_o      (hit_count),
        .miss_count_o     (miss_count),
        .mem_txn_count_o  (mem_txn_count),
        .wb_load_count_o  (wb_load_count),
        .wb_store_count_o (wb_store_count)
    );

    // Initial memory contents.
    function automatic logic [DATA_WIDTH-1:0] init_word(input logic [ADDR_WIDTH-1:0] addr);
        return {addr ^ 16'h5a3c, addr + 16'h1234};
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, sig, got, want);
        error_count++;
    endtask

    task automatic predict_access(input logic we, input logic [ADDR_WIDTH-1:0] addr,
                                  input logic [DATA_WIDTH-1:0] wdata,
                                  output logic hit, output logic [DATA_WIDTH-1:0] rdata);
        logic [INDEX_BITS-1:0] idx;
        logic [TAG_BITS-1:0]   tag;
        logic [ADDR_WIDTH-1:0] victim;
        idx = addr[OFFSET_BITS +: INDEX_BITS];
        tag = addr[ADDR_WIDTH-1 -: TAG_BITS];
        hit = m_valid[idx] && (m_tag[idx] == tag);
        if (hit)
        begin
            exp_hits++;
            if (we)
            begin
                m_data[idx] = wdata;
                m_dirty[idx] = 1'b1;
            end
        end
        else
        begin
            exp_misses++;
            if (m_valid[idx] && m_dirty[idx])  // Dirty victim goes back first.
            begin
                victim = {m_tag[idx], idx, {OFFSET_BITS{1'b0}}};
                exp_txn_q.push_back({1'b1, victim, m_data[idx]});
                model_mem[victim] = m_data[idx];
                exp_txns++;
                if (we)
                    exp_wb_store++;
                else
                    exp_wb_load++;
            end
            m_valid[idx] = 1'b1;
            m_tag[idx] = tag;
            m_dirty[idx] = we;
            if (we)
                m_data[idx] = wdata;  // Store miss needs no fill.
            else
            begin
                exp_txn_q.push_back({1'b0, addr, {DATA_WIDTH{1'b0}}});
                exp_txns++;
                m_data[idx] = model_mem.exists(addr) ? model_mem[addr] : init_word(addr);
            end
        end
        rdata = m_data[idx];
    endtask

    task automatic compare_mem_traffic();
        logic [TXN_W-1:0]      seen;
        logic [TXN_W-1:0]      want;
        logic [ADDR_WIDTH-1:0] seen_addr;
        logic [ADDR_WIDTH-1:0] want_addr;
        while (seen_txn_q.size() > 0)
        begin
            seen = seen_txn_q.pop_front();
            seen_addr = seen[DATA_WIDTH +: ADDR_WIDTH];
            if (exp_txn_q.size() == 0)
            begin
                $display("** Error at %0t ns: memory access to 0x%0h was not expected",
                         $time, seen_addr);
                error_count++;
            end
            else
            begin
                want = exp_txn_q.pop_front();
                want_addr = want[DATA_WIDTH +: ADDR_WIDTH];
                if (seen[TXN_W-1] !== want[TXN_W-1])
                    report_mismatch("mem_we_o", 32'(seen[TXN_W-1]), 32'(want[TXN_W-1]));
                if (seen_addr !== want_addr)
                    report_mismatch("mem_addr_o", 32'(seen_addr), 32'(want_addr));
                if (want[TXN_W-1] && (seen[DATA_WIDTH-1:0] !== want[DATA_WIDTH-1:0]))
                    report_mismatch("mem_wdata_o", seen[DATA_WIDTH-1:0], want[DATA_WIDTH-1:0]);
            end
        end
        if (exp_txn_q.size() != 0)
        begin
            $display("** Error at %0t ns: %0d expected memory accesses never happened",
                     $time, exp_txn_q.size());
            error_count++;
            exp_txn_q.delete();
        end
    endtask

    // Starts and ends on a falling edge.
    task automatic run_access(input logic we, input logic [ADDR_WIDTH-1:0] addr,
                              input logic [DATA_WIDTH-1:0] wdata);
        logic                  hit;
        logic [DATA_WIDTH-1:0] exp_rdata;
        int                    gnt_cycles;
        int                    rv_cycles;
        predict_access(we, addr, wdata, hit, exp_rdata);
        proc_req = 1'b1;
        proc_addr = addr;
        proc_we = we;
        proc_wdata = wdata;
        @(negedge clk);
        gnt_cycles = 1;
        while (!proc_gnt)
        begin
            @(negedge clk);
            gnt_cycles++;
        end
        proc_req = 1'b0;
        @(negedge clk);
        rv_cycles = 1;
        while (!proc_rvalid)
        begin
            @(negedge clk);
            rv_cycles++;
        end
        if (!we && (proc_rdata !== exp_rdata))
            report_mismatch("proc_rdata_o", proc_rdata, exp_rdata);
        if (hit && (gnt_cycles != 2))
            report_mismatch("proc_gnt_o latency", gnt_cycles, 2);
        if (hit && (rv_cycles != 1))
            report_mismatch("proc_rvalid_o latency", rv_cycles, 1);
        compare_mem_traffic();
        @(negedge clk);
    endtask

    task automatic check_counters();
        if (hit_count !== exp_hits)
            report_mismatch("hit_count_o", hit_count, exp_hits);
        if (miss_count !== exp_misses)
            report_mismatch("miss_count_o", miss_count, exp_misses);
        if (mem_txn_count !== exp_txns)
            report_mismatch("mem_txn_count_o", mem_txn_count, exp_txns);
        if (wb_load_count !== exp_wb_load)
            report_mismatch("wb_load_count_o", wb_load_count, exp_wb_load);
        if (wb_store_count !== exp_wb_store)
            report_mismatch("wb_store_count_o", wb_store_count, exp_wb_store);
    endtask

    task automatic close_test(input string name);
        if (error_count == start_errors)
        begin
            pass_count++;
            $display("PASS  %s", name);
        end
        else
        begin
            fail_count++;
            $display("FAIL  %s (%0d errors)", name, error_count - start_errors);
        end
        start_errors = error_count;
    endtask

    // Memory responder waits 0 to 3 cycles before grant and before rvalid.
    initial
    begin : mem_responder
        logic [ADDR_WIDTH-1:0] addr;
        mem_gnt = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata = '0;
        forever
        begin
            @(negedge clk);
            mem_rvalid = 1'b0;
            if (mem_req)
            begin
                addr = mem_addr;
                seen_txn_q.push_back({mem_we, mem_addr, mem_wdata});
                if (mem_we)
                    mem_words[addr] = mem_wdata;
                repeat ($urandom % 4) @(negedge clk);
                mem_gnt = 1'b1;
                @(negedge clk);
                mem_gnt = 1'b0;
                repeat ($urandom % 4) @(negedge clk);
                mem_rvalid = 1'b1;
                mem_rdata = mem_words.exists(addr) ? mem_words[addr] : init_word(addr);
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout: no progress after %0d cycles", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    initial
    begin
        logic                  rand_we;
        logic [ADDR_WIDTH-1:0] rand_addr;
        logic [DATA_WIDTH-1:0] rand_wdata;
        proc_req = 1'b0;
        proc_addr = '0;
        proc_we = 1'b0;
        proc_wdata = '0;
        exp_hits = 0;
        exp_misses = 0;
        exp_txns = 0;
        exp_wb_load = 0;
        exp_wb_store = 0;
        error_count = 0;
        start_errors = 0;
        pass_count = 0;
        fail_count = 0;
        for (int i = 0; i < NUM_LINES; i++)
        begin
            m_valid[i] = 1'b0;
            m_dirty[i] = 1'b0;
        end
        void'($urandom(32'hdd82));
        wait (rst_n === 1'b1);
        @(negedge clk);

        check_counters();
        if (proc_gnt !== 1'b0)
            report_mismatch("proc_gnt_o", 32'(proc_gnt), 32'd0);
        if (proc_rvalid !== 1'b0)
            report_mismatch("proc_rvalid_o", 32'(proc_rvalid), 32'd0);
        if (mem_req !== 1'b0)
            report_mismatch("mem_req_o", 32'(mem_req), 32'd0);
        close_test("reset state");

        repeat (4) run_access(1'b0, 16'h0040, '0);
        check_counters();
        close_test("repeated loads");

        run_access(1'b1, 16'h0084, 32'hcafe_f00d);
        run_access(1'b0, 16'h0084, '0);
        check_counters();
        close_test("store then load");

        // All on index 2, so each miss evicts the previous line.
        run_access(1'b1, 16'h0108, 32'h1111_aaaa);
        run_access(1'b0, 16'h0208, '0);
        run_access(1'b1, 16'h0308, 32'h2222_bbbb);
        run_access(1'b1, 16'h0108, 32'h3333_cccc);
        run_access(1'b0, 16'h0108, '0);
        run_access(1'b0, 16'h0208, '0);  // Second load write-back.
        check_counters();
        close_test("dirty eviction");

        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            rand_we = 1'($urandom);
            rand_addr = ADDR_WIDTH'(($urandom % 64) << OFFSET_BITS);
            rand_wdata = $urandom;
            run_access(rand_we, rand_addr, rand_wdata);
        end
        check_counters();
        close_test("random traffic");

        $display("Summary: %0d passed, %0d failed, %0d errors",
                 pass_count, fail_count, error_count);
        if (fail_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
)
(
    output logic clk_o,
    output logic rst_n_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset released on a falling edge, like all other inputs.
    initial
    begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/dm_cache_cfg_pkg.sv
hdl/dm_cache_types_pkg.sv
hdl/dm_tag_array.sv
hdl/dm_data_array.sv
hdl/dm_cache_ctrl.sv
hdl/dm_perf_counters.sv
hdl/dm_cache_top.sv
tests/tb_clock_gen.sv
tests/dm_cache_tb.sv
